//--- hdl/br_column.sv
// Boundary register column with front and back banks and word-enabled writes
`default_nettype none

module br_column import br_pkg::*; #(
   parameter col_idx_t COL = '0                             // Own column index
) (
   input  logic   ACLK,
   input  logic   RSTN,
   input  br_wr_t wr,
   output col_t   front,
   output col_t   back
);

   logic hit;                                               // Request aimed here

   assign hit = (wr.col == COL);

   always_ff @(posedge ACLK or negedge RSTN) begin
      if (!RSTN) begin
         front <= '0;
         back  <= '0;
      end else if (hit) begin
         for (int w = 0; w < WORDS_PER_COL; w++) begin
            if (wr.word_en[w] && wr.front_en)
               front[w*WORD_BITS +: WORD_BITS] <= wr.data[w*WORD_BITS +: WORD_BITS];
            if (wr.word_en[w] && wr.back_en)
               back[w*WORD_BITS +: WORD_BITS] <= wr.data[w*WORD_BITS +: WORD_BITS];
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/br_load_align.sv
// Load aligner picking one lane per memory read port and aligning it by load mode
`default_nettype none

module br_load_align import br_pkg::*; (
   input  col_t   mr0,
   input  col_t   mr1,
   input  lane_t  ea0,
   input  lane_t  ea1,
   input  ld_op_e ea0op,
   input  ld_op_e ea1op,
   output lane_t  ld_lo,
   output lane_t  ld_hi
);

   lane_t sel0;                                             // Lane picked from port 0
   lane_t sel1;                                             // Lane picked from port 1

   // Align one lane; fill supplies the bytes shifted in from above
   function automatic lane_t align_lane(input ld_op_e     op,
                                        input logic [2:0] ofs,
                                        input lane_t      din,
                                        input lane_t      fill);
      logic [2*LANE_BITS-1:0] pair;
      lane_t                  res;
      pair = {fill, din} >> {ofs, 3'b000};                  // Byte offset shift
      case (op)
         OP_LDWR: res = lane_t'(din[{ofs[2], 5'b00000} +: 32]);  // Zero-extended word
         OP_LDBR: res = lane_t'(din[{ofs, 3'b000} +: 8]);        // Zero-extended byte
         default: res = pair[LANE_BITS-1:0];                     // Unaligned 64-bit
      endcase
      return res;
   endfunction

   // Address bits 4:3 pick the lane
   assign sel0 = mr0[int'(ea0[4:3])*LANE_BITS +: LANE_BITS];
   assign sel1 = mr1[int'(ea1[4:3])*LANE_BITS +: LANE_BITS];

   assign ld_hi = align_lane(ea1op, ea1[2:0], sel1, '0);     // Zero fill on top
   assign ld_lo = align_lane(ea0op, ea0[2:0], sel0, sel1);   // Port 1 bytes fill the top

endmodule

`default_nettype wire

//--- hdl/br_pkg.sv
// Boundary register package with widths, vector types, command enums and request structs
`default_nettype none

package br_pkg;

   // Array geometry
   localparam int NUM_COLS      = 4;                        // Columns in the boundary register
   localparam int NUM_LANES     = 4;                        // 64-bit lanes per column
   localparam int LANE_BITS     = 64;
   localparam int COL_BITS      = 256;
   localparam int WORDS_PER_COL = 8;                        // 32-bit words per column
   localparam int WORD_BITS     = COL_BITS / WORDS_PER_COL; // Write granule

   // Ring addressing
   localparam int CHIP_BITS = 2;
   localparam int ROW_BITS  = 6;
   localparam logic [2:0] TR_TY_REG = 3'd1;                 // Ring type aimed at registers

   typedef logic [LANE_BITS-1:0]          lane_t;
   typedef logic [COL_BITS-1:0]           col_t;
   typedef logic [NUM_COLS*COL_BITS-1:0]  bout_t;           // Column 0 in low bits
   typedef logic [CHIP_BITS-1:0]          chip_t;
   typedef logic [ROW_BITS-1:0]           row_t;
   typedef logic [1:0]                    col_idx_t;        // Column or phase number
   typedef logic [WORDS_PER_COL-1:0]      word_en_t;

   typedef enum logic [1:0] {
      CMD_NOP  = 2'd0,
      CMD_SCON = 2'd1,                                      // Configuration load
      CMD_EXEC = 2'd2,                                      // Execution
      CMD_RSVD = 2'd3
   } cmd_e;

   // Load op of an address port; unknown codes act as OP_LDR
   typedef enum logic [4:0] {
      OP_LDR  = 5'd1,                                       // Unaligned 64-bit
      OP_LDWR = 5'd2,                                       // 32-bit word
      OP_LDBR = 5'd3                                        // Byte
   } ld_op_e;

   // Lane source select
   typedef enum logic [1:0] {
      BRS_OFF,                                              // Lane kept
      BRS_MR1,                                              // Memory read port 1 lane
      BRS_TX,                                               // Transfer input
      BRS_ALT                                               // Aligned load or ext data
   } brs_e;

   typedef struct packed {
      logic [COL_BITS-19:0] rsvd;                           // Bits 255:18 unused
      ld_op_e               ea1op;                          // Bits 17:13
      ld_op_e               ea0op;                          // Bits 12:8
      brs_e [NUM_LANES-1:0] brs;                            // Lane 0 in bits 1:0
   } br_conf_t;

   typedef struct packed {
      logic [2:0]  ty;
      logic [31:0] addr;                                    // Chip 17:16, row 12:7, col 6:5
      logic [31:0] dm;                                      // Byte mask with every 4th bit used
      col_t        data;
   } lmring_tr_t;

   typedef struct packed {
      col_idx_t col;                                        // Target column
      logic     front_en;
      logic     back_en;
      word_en_t word_en;
      col_t     data;
   } br_wr_t;

   typedef struct packed {
      col_idx_t phase;
      logic     frame_end;                                  // Last phase of the frame
      logic     show_back;                                  // Back bank visible
   } br_phase_t;

endpackage

`default_nettype wire

//--- hdl/br_readout.sv
// Boundary register readout selecting the visible bank and holding the frame valid flag
`default_nettype none

module br_readout import br_pkg::*; (
   input  logic      ACLK,
   input  logic      RSTN,
   input  br_phase_t phase,
   input  logic      tr_valid,
   input  bout_t     front_all,
   input  bout_t     back_all,
   output bout_t     bout,
   output logic      bout_valid
);

   // Visible bank of all columns
   assign bout = phase.show_back ? back_all : front_all;

   // Valid sampled once per frame
   always_ff @(posedge ACLK or negedge RSTN) begin
      if (!RSTN)
         bout_valid <= 1'b0;
      else if (phase.frame_end)
         bout_valid <= tr_valid;                            // Held for the next frame
   end

endmodule

`default_nettype wire

//--- hdl/br_stage.sv
// Boundary register stage top with write source, four columns and readout
`default_nettype none

module br_stage import br_pkg::*; (
   input  logic              ACLK,
   input  logic              RSTN,
   input  cmd_e              cmd,
   input  chip_t             chip,
   input  row_t              l_row,
   input  logic [ROW_BITS:0] scon_count,
   input  logic              unit1_exec,
   input  br_conf_t          conf0,
   input  br_conf_t          conf1,
   input  br_conf_t          conf2,
   input  br_conf_t          conf3,
   input  logic              tr_valid,
   input  logic              lmring_ful,
   input  lmring_tr_t        tr,
   input  lane_t             tx0,
   input  lane_t             tx1,
   input  lane_t             tx2,
   input  lane_t             tx3,
   input  lane_t             exd,
   input  lane_t             ea0,
   input  lane_t             ea0woofs,
   input  lane_t             ea1,
   input  lane_t             ea1woofs,
   input  col_t              mr0,
   input  col_t              mr1,
   output bout_t             bout,
   output logic              bout_valid
);

   br_wr_t    wr;                                           // Shared write request
   br_phase_t phase;
   bout_t     front_all;                                    // Column 0 lowest
   bout_t     back_all;

   br_write_source u_br_write_source (
      .ACLK       (ACLK),
      .RSTN       (RSTN),
      .cmd        (cmd),
      .chip       (chip),
      .l_row      (l_row),
      .scon_count (scon_count),
      .unit1_exec (unit1_exec),
      .conf0      (conf0),
      .conf1      (conf1),
      .conf2      (conf2),
      .conf3      (conf3),
      .lmring_ful (lmring_ful),
      .tr         (tr),
      .tx0        (tx0),
      .tx1        (tx1),
      .tx2        (tx2),
      .tx3        (tx3),
      .exd        (exd),
      .ea0        (ea0),
      .ea0woofs   (ea0woofs),
      .ea1        (ea1),
      .ea1woofs   (ea1woofs),
      .mr0        (mr0),
      .mr1        (mr1),
      .wr         (wr),
      .phase      (phase)
   );

   for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
      br_column #(
         .COL (col_idx_t'(c))
      ) u_br_column (
         .ACLK  (ACLK),
         .RSTN  (RSTN),
         .wr    (wr),
         .front (front_all[c*COL_BITS +: COL_BITS]),
         .back  (back_all[c*COL_BITS +: COL_BITS])
      );
   end

   br_readout u_br_readout (
      .ACLK       (ACLK),
      .RSTN       (RSTN),
      .phase      (phase),
      .tr_valid   (tr_valid),
      .front_all  (front_all),
      .back_all   (back_all),
      .bout       (bout),
      .bout_valid (bout_valid)
   );

endmodule

`default_nettype wire

//--- hdl/br_write_source.sv
// Write source with phase counter, bank swap, ring decode and write request build
`default_nettype none

module br_write_source import br_pkg::*; (
   input  logic                ACLK,
   input  logic                RSTN,
   input  cmd_e                cmd,
   input  chip_t               chip,
   input  row_t                l_row,
   input  logic [ROW_BITS:0]   scon_count,
   input  logic                unit1_exec,
   input  br_conf_t            conf0,
   input  br_conf_t            conf1,
   input  br_conf_t            conf2,
   input  br_conf_t            conf3,
   input  logic                lmring_ful,
   input  lmring_tr_t          tr,
   input  lane_t               tx0,
   input  lane_t               tx1,
   input  lane_t               tx2,
   input  lane_t               tx3,
   input  lane_t               exd,
   input  lane_t               ea0,
   input  lane_t               ea0woofs,
   input  lane_t               ea1,
   input  lane_t               ea1woofs,
   input  col_t                mr0,
   input  col_t                mr1,
   output br_wr_t              wr,
   output br_phase_t           phase
);

   col_idx_t              cnt;                              // Free-running phase
   logic                  swap;                             // 0 fills back, 1 fills front
   br_conf_t              conf;                             // Word of the current phase
   chip_t                 tr_chip;
   row_t                  tr_row;
   col_idx_t              tr_col;
   logic                  ring_hit;
   word_en_t              ring_word_en;
   word_en_t              exec_word_en;
   lane_t                 ld_lo;
   lane_t                 ld_hi;
   lane_t [NUM_LANES-1:0] mr1_lane;
   lane_t [NUM_LANES-1:0] tx_lane;
   lane_t [NUM_LANES-1:0] alt_lane;
   lane_t [NUM_LANES-1:0] exec_lane;

   always_ff @(posedge ACLK or negedge RSTN) begin
      if (!RSTN) begin
         cnt  <= '0;
         swap <= 1'b0;
      end else begin
         cnt <= cnt + 2'd1;                                 // Wraps 3 to 0
         if (cnt == 2'd3)
            swap <= ~swap;                                  // Banks trade at frame end
      end
   end

   always_comb begin
      case (cnt)
         2'd0:    conf = conf0;
         2'd1:    conf = conf1;
         2'd2:    conf = conf2;
         default: conf = conf3;
      endcase
   end

   // Ring address fields
   assign tr_chip  = tr.addr[16 +: CHIP_BITS];
   assign tr_row   = tr.addr[7 +: ROW_BITS];
   assign tr_col   = tr.addr[6:5];
   assign ring_hit = (cmd == CMD_NOP) && lmring_ful && (tr.ty == TR_TY_REG) &&
                     (tr_chip == chip || tr_chip == '0) &&  // Chip 0 is broadcast
                     (tr_row == l_row);

   always_comb begin
      for (int w = 0; w < WORDS_PER_COL; w++)
         ring_word_en[w] = tr.dm[4*w];                      // One mask bit per word
   end

   br_load_align u_br_load_align (
      .mr0   (mr0),
      .mr1   (mr1),
      .ea0   (ea0),
      .ea1   (ea1),
      .ea0op (conf.ea0op),
      .ea1op (conf.ea1op),
      .ld_lo (ld_lo),
      .ld_hi (ld_hi)
   );

   assign mr1_lane = mr1;
   assign tx_lane  = {tx3, tx2, tx1, tx0};
   assign alt_lane = {ea1woofs,
                      (conf.brs[3] == BRS_ALT) ? ea0woofs : exd, // Lane 2 steals ea0woofs
                      ld_hi, ld_lo};

   // Per-lane source of an execution load
   always_comb begin
      for (int k = 0; k < NUM_LANES; k++) begin
         exec_word_en[2*k +: 2] = {2{conf.brs[k] != BRS_OFF}};
         case (conf.brs[k])
            BRS_MR1: exec_lane[k] = mr1_lane[k];
            BRS_TX:  exec_lane[k] = tx_lane[k];
            BRS_ALT: exec_lane[k] = alt_lane[k];
            default: exec_lane[k] = '0;                     // Masked by word enable
         endcase
      end
   end

   // Ring has priority over config and exec
   always_comb begin
      wr     = '0;
      wr.col = cnt;
      if (ring_hit) begin
         wr.col      = tr_col;
         wr.front_en = 1'b1;                                // Both banks
         wr.back_en  = 1'b1;
         wr.word_en  = ring_word_en;
         wr.data     = tr.data;
      end else if (cmd == CMD_SCON && unit1_exec && !scon_count[0]) begin
         wr.front_en = 1'b1;                                // Front only
         wr.word_en  = '1;
         wr.data     = conf;
      end else if (cmd == CMD_EXEC) begin
         wr.front_en = swap;                                // Hidden bank
         wr.back_en  = ~swap;
         wr.word_en  = exec_word_en;
         wr.data     = exec_lane;
      end
   end

   assign phase.phase     = cnt;
   assign phase.frame_end = (cnt == 2'd3);
   assign phase.show_back = swap && (cmd != CMD_SCON);      // Config sees front only

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the boundary register stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary -j 0 --top-module br_stage_tb -f sim.f -o br_stage_sim > build.log 2>&1 \
   && ./obj_dir/br_stage_sim > sim.log 2>&1
cat build.log sim.log 2> /dev/null
grep -q "STATUS: PASS" sim.log 2> /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- sim.f
+incdir+verification
hdl/br_pkg.sv
hdl/br_load_align.sv
hdl/br_write_source.sv
hdl/br_column.sv
hdl/br_readout.sv
hdl/br_stage.sv
verification/br_stage_tb.sv

//--- verification/br_model.svh
// Boundary register cycle model with phase, bank swap, both banks, alignment and valid flag
`ifndef BR_MODEL_SVH
`define BR_MODEL_SVH

col_t     m_front [NUM_COLS];                               // Model front banks
col_t     m_back  [NUM_COLS];                               // Model back banks
col_idx_t m_phase;
logic     m_swap;
logic     m_valid;

task automatic model_reset();
   for (int c = 0; c < NUM_COLS; c++) begin
      m_front[c] = '0;
      m_back[c]  = '0;
   end
   m_phase = '0;
   m_swap  = 1'b0;
   m_valid = 1'b0;
endtask

// Aligned load of one port built byte by byte
function automatic lane_t model_align(input logic [4:0] op, input lane_t addr,
                                      input col_t mr, input lane_t fill_lane,
                                      input bit fill_en);
   lane_t sel;
   lane_t res;
   int    ofs;
   sel = mr[int'(addr[4:3])*LANE_BITS +: LANE_BITS];      // Lane by address bits 4:3
   ofs = int'(addr[2:0]);
   res = '0;
   if (op == 5'd2)
      res[31:0] = addr[2] ? sel[63:32] : sel[31:0];         // Word load
   else if (op == 5'd3)
      res[7:0] = sel[ofs*8 +: 8];                           // Byte load
   else begin
      for (int b = 0; b < 8; b++) begin
         if (b + ofs < 8)
            res[b*8 +: 8] = sel[(b+ofs)*8 +: 8];
         else if (fill_en)
            res[b*8 +: 8] = fill_lane[(b+ofs-8)*8 +: 8];   // Bytes from port 1 lane
      end
   end
   return res;
endfunction

// Visible bank for the current command
function automatic bout_t model_bout();
   bout_t b;
   for (int c = 0; c < NUM_COLS; c++)
      b[c*COL_BITS +: COL_BITS] = (m_swap && cmd != CMD_SCON) ? m_back[c] : m_front[c];
   return b;
endfunction

// One clock edge of the model using the inputs of the ending cycle
task automatic model_step();
   br_conf_t c;
   col_t     data;
   word_en_t wen;
   logic     fe;
   logic     be;
   col_idx_t col;
   lane_t    lane;
   lane_t    fill;
   c    = conf_in[m_phase];
   data = '0;
   wen  = '0;
   fe   = 1'b0;
   be   = 1'b0;
   col  = m_phase;
   if (cmd == CMD_NOP && lmring_ful && tr.ty == TR_TY_REG &&
       (tr.addr[17:16] == chip || tr.addr[17:16] == 2'd0) && tr.addr[12:7] == l_row) begin
      col  = tr.addr[6:5];
      fe   = 1'b1;
      be   = 1'b1;
      data = tr.data;
      for (int w = 0; w < WORDS_PER_COL; w++)
         wen[w] = tr.dm[4*w];
   end else if (cmd == CMD_SCON && unit1_exec && !scon_count[0]) begin
      fe   = 1'b1;
      wen  = '1;
      data = c;
   end else if (cmd == CMD_EXEC) begin
      fe   = m_swap;                                        // Hidden bank only
      be   = ~m_swap;
      fill = mr1[int'(ea1[4:3])*LANE_BITS +: LANE_BITS];
      for (int k = 0; k < NUM_LANES; k++) begin
         case (c.brs[k])
            BRS_MR1: lane = mr1[k*LANE_BITS +: LANE_BITS];
            BRS_TX:  lane = tx_in[k];
            BRS_ALT: begin
               if (k == 0)
                  lane = model_align(c.ea0op, ea0, mr0, fill, 1'b1);
               else if (k == 1)
                  lane = model_align(c.ea1op, ea1, mr1, fill, 1'b0);
               else if (k == 2)
                  lane = (c.brs[3] == BRS_ALT) ? ea0woofs : exd;
               else
                  lane = ea1woofs;
            end
            default: lane = '0;
         endcase
         wen[2*k]   = (c.brs[k] != BRS_OFF);
         wen[2*k+1] = (c.brs[k] != BRS_OFF);
         data[k*LANE_BITS +: LANE_BITS] = lane;
      end
   end
   for (int w = 0; w < WORDS_PER_COL; w++) begin
      if (wen[w] && fe)
         m_front[col][w*32 +: 32] = data[w*32 +: 32];
      if (wen[w] && be)
         m_back[col][w*32 +: 32] = data[w*32 +: 32];
   end
   if (m_phase == 2'd3) begin
      m_swap  = ~m_swap;                                    // Frame end swap
      m_valid = tr_valid;
   end
   m_phase = m_phase + 2'd1;
endtask

`endif

//--- verification/br_stage_tb.sv
// Boundary register stage testbench with random stimulus checked against a cycle model
`default_nettype none

module br_stage_tb import br_pkg::*; ();

   localparam int  SEED       = 32'h4b9a;
   localparam int  RST_CYC    = 3;
   localparam int  N_RESET    = 8;
   localparam int  N_RING     = 300;
   localparam int  N_SCON     = 100;
   localparam int  N_EXEC     = 300;
   localparam int  N_ALIGN    = 300;
   localparam int  N_VALID    = 200;
   localparam int  TOTAL_CYC  = RST_CYC + N_RESET + N_RING + N_SCON + N_EXEC + N_ALIGN + N_VALID;
   localparam time WATCHDOG_T = TOTAL_CYC * 10 * 2;

   logic              ACLK;
   logic              RSTN;
   cmd_e              cmd;
   chip_t             chip;
   row_t              l_row;
   logic [ROW_BITS:0] scon_count;
   logic              unit1_exec;
   br_conf_t          conf_in [NUM_COLS];                   // Per-phase config words
   logic              tr_valid;
   logic              lmring_ful;
   lmring_tr_t        tr;
   lane_t             tx_in [NUM_LANES];
   lane_t             exd;
   lane_t             ea0;
   lane_t             ea0woofs;
   lane_t             ea1;
   lane_t             ea1woofs;
   col_t              mr0;
   col_t              mr1;
   bout_t             bout;
   logic              bout_valid;
   int                errors;
   int                checks;
   int                seed_word;

   `include "br_model.svh"

   br_stage u_br_stage (
      .ACLK (ACLK), .RSTN (RSTN), .cmd (cmd), .chip (chip), .l_row (l_row),
      .scon_count (scon_count), .unit1_exec (unit1_exec),
      .conf0 (conf_in[0]), .conf1 (conf_in[1]), .conf2 (conf_in[2]), .conf3 (conf_in[3]),
      .tr_valid (tr_valid), .lmring_ful (lmring_ful), .tr (tr),
      .tx0 (tx_in[0]), .tx1 (tx_in[1]), .tx2 (tx_in[2]), .tx3 (tx_in[3]),
      .exd (exd), .ea0 (ea0), .ea0woofs (ea0woofs), .ea1 (ea1), .ea1woofs (ea1woofs),
      .mr0 (mr0), .mr1 (mr1), .bout (bout), .bout_valid (bout_valid)
   );

   initial begin
      ACLK = 1'b0;
      forever #5 ACLK = ~ACLK;
   end

   initial begin
      #(WATCHDOG_T);
      $display("Watchdog expired at %0t before the tests completed", $time);
      $display("STATUS: FAIL");
      $finish;
   end

   function automatic lane_t rand_lane();
      return {$urandom, $urandom};
   endfunction

   function automatic col_t rand_col();
      col_t c;
      for (int i = 0; i < WORDS_PER_COL; i++)
         c[i*32 +: 32] = $urandom;
      return c;
   endfunction

   // Mostly the three defined load ops with an occasional stray code
   function automatic ld_op_e pick_op();
      logic [4:0] v;
      case ($urandom % 4)
         0:       v = 5'd1;
         1:       v = 5'd2;
         2:       v = 5'd3;
         default: v = 5'($urandom);
      endcase
      return ld_op_e'(v);
   endfunction

   task automatic check_bout(input bout_t got, input bout_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: bout got %h expected %h at %0t", got, exp, $time);
      end
   endtask

   task automatic check_valid(input logic got, input bit exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: bout_valid got %h expected %h at %0t", got, exp, $time);
      end
   endtask

   task automatic randomize_inputs();
      cmd        = cmd_e'(2'($urandom_range(0, 3)));
      chip       = chip_t'($urandom);
      l_row      = row_t'($urandom);
      scon_count = 7'($urandom);
      unit1_exec = 1'($urandom);
      for (int k = 0; k < NUM_COLS; k++)
         conf_in[k] = br_conf_t'(rand_col());
      tr_valid   = 1'($urandom);
      lmring_ful = 1'($urandom);
      tr.ty      = 3'($urandom);
      tr.addr    = $urandom;
      tr.dm      = $urandom;
      tr.data    = rand_col();
      for (int k = 0; k < NUM_LANES; k++)
         tx_in[k] = rand_lane();
      exd      = rand_lane();
      ea0      = rand_lane();
      ea0woofs = rand_lane();
      ea1      = rand_lane();
      ea1woofs = rand_lane();
      mr0      = rand_col();
      mr1      = rand_col();
   endtask

   // Steer the random inputs toward one write path
   task automatic bias_inputs(input int kind);
      case (kind)
         0: begin                                           // Idle after reset
            cmd        = CMD_NOP;
            lmring_ful = 1'b0;
            tr_valid   = 1'b1;
         end
         1: begin                                           // Ring write
            if ($urandom % 8 != 0)
               cmd = CMD_NOP;
            lmring_ful = ($urandom % 4 != 0);
            if ($urandom % 4 != 0)
               tr.ty = TR_TY_REG;
            case ($urandom % 3)
               0:       tr.addr[17:16] = chip;
               1:       tr.addr[17:16] = 2'd0;              // Broadcast
               default: tr.addr[17:16] = chip_t'($urandom);
            endcase
            if ($urandom % 4 != 0)
               tr.addr[12:7] = l_row;
         end
         2: cmd = CMD_SCON;
         3: cmd = CMD_EXEC;
         4: begin                                           // Aligned lanes 0 and 1
            cmd = CMD_EXEC;
            for (int k = 0; k < NUM_COLS; k++) begin
               conf_in[k].brs[0] = BRS_ALT;
               conf_in[k].brs[1] = BRS_ALT;
               conf_in[k].ea0op  = pick_op();
               conf_in[k].ea1op  = pick_op();
            end
         end
         default: ;                                         // Fully random
      endcase
   endtask

   // Check mid-cycle, then advance model and DUT by one edge
   task automatic tick();
      @(negedge ACLK);
      check_bout(bout, model_bout());
      check_valid(bout_valid, m_valid);
      model_step();
      @(posedge ACLK);
      #1;
   endtask

   task automatic run_test(input string name, input int cycles, input int kind);
      int err_before;
      err_before = errors;
      for (int i = 0; i < cycles; i++) begin
         randomize_inputs();
         bias_inputs(kind);
         tick();
      end
      $display("Test %-10s %0d cycles, %0d errors", name, cycles, errors - err_before);
   endtask

   initial begin
      errors    = 0;
      checks    = 0;
      seed_word = $urandom(SEED);
      RSTN      = 1'b0;
      randomize_inputs();
      bias_inputs(0);
      model_reset();
      repeat (RST_CYC - 1) @(posedge ACLK);
      @(negedge ACLK);
      check_bout(bout, '0);                                 // Cleared in reset
      check_valid(bout_valid, 1'b0);
      @(posedge ACLK);
      #1;
      RSTN = 1'b1;
      run_test("reset", N_RESET, 0);
      run_test("ring_write", N_RING, 1);
      run_test("conf_load", N_SCON, 2);
      run_test("exec_load", N_EXEC, 3);
      run_test("alignment", N_ALIGN, 4);
      run_test("valid_flag", N_VALID, 5);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
